/* logic/bf_ctrl_pkg.sv */
// beam-forming controller definitions
`default_nettype none

package bf_ctrl_pkg;

    // --------------------
    // widths
    localparam int FRAME_W  = 4;   // incoming frame counter
    localparam int STAMP_W  = 5;   // frame stamp out
    localparam int CNT_W    = 5;   // pass counter
    localparam int PAD_W    = 20;  // padding size
    localparam int OFFSET_W = 32;  // ram0 frame offset
    localparam int NUM_CH   = 4;   // processing channels ch0..ch3

    // --------------------
    // sequencer states
    typedef enum logic [4:0] {
        ST_WAIT_SPEC,    // spec read wait, idle
        ST_WAIT_TRANS,   // sound speed / position transfer
        ST_LOAD_A_CH0,   // first input ram load
        ST_LOAD_A_CH1,
        ST_LOAD_A_CH2,
        ST_LOAD_A_CH3,
        ST_LOAD_B_CH0,   // second input ram load
        ST_LOAD_B_CH1,
        ST_LOAD_B_CH2,
        ST_LOAD_B_CH3,
        ST_CALC_CH0,     // calculation
        ST_CALC_CH1,
        ST_CALC_CH2,
        ST_CALC_CH3,
        ST_WRITE_CH0,    // ddr write-back, in channel order
        ST_WRITE_CH1,
        ST_WRITE_CH2,
        ST_WRITE_CH3,
        ST_END_JUDGE     // pass done, next pass or back to idle
    } seq_state_t;

endpackage

`default_nettype wire

/* logic/frame_stamp.sv */
// frame tracking and stamp
`timescale 1ns/1ps
`default_nettype none

module frame_stamp #(
    parameter logic [bf_ctrl_pkg::FRAME_W-1:0] FRAME_MAX = 4'd7,  // frame reg reset value
    parameter logic [bf_ctrl_pkg::CNT_W-1:0]   CALC_NUM  = 5'd2   // passes per frame
) (
    input  logic                             i_arst,          // clock
    input  logic                             i_clk156m,       // async reset
    input  logic [bf_ctrl_pkg::FRAME_W-1:0]  i_frame_time,    // live frame counter
    input  logic                             i_idle,          // sequencer in wait-spec
    input  logic                             i_system,        // 1 ta, 0 fa
    input  logic                             i_calc_start,    // stamp load strobe
    input  logic [bf_ctrl_pkg::CNT_W-1:0]    i_pass_cnt,
    input  logic [bf_ctrl_pkg::OFFSET_W-1:0] i_frame_offset,
    output logic                             o_frame_chg,     // frame moved on
    output logic [bf_ctrl_pkg::STAMP_W-1:0]  o_frame_time,    // frame + pass stamp
    output logic [bf_ctrl_pkg::OFFSET_W-1:0] o_frame_offset0
);

    import bf_ctrl_pkg::*;

    logic [FRAME_W-1:0] r_frame;  // last seen frame

    // --------------------
    // frame change detect
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_frame <= FRAME_MAX;
        end else begin
            r_frame <= i_frame_time;
        end
    end

    assign o_frame_chg = (i_frame_time != r_frame);  // comb, restarts the sequencer

    // --------------------
    // stamp, split between frame and pass bits by CALC_NUM
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_frame_time <= '0;
        end else if (i_calc_start) begin
            case (CALC_NUM)
                5'd16:   o_frame_time <= {r_frame[0],   i_pass_cnt[3:0]};
                5'd8:    o_frame_time <= {r_frame[1:0], i_pass_cnt[2:0]};
                5'd4:    o_frame_time <= {r_frame[2:0], i_pass_cnt[1:0]};
                5'd2:    o_frame_time <= {r_frame[3:0], i_pass_cnt[0]};
                default: o_frame_time <= {1'b0, r_frame};  // single pass, frame only
            endcase
        end
    end

    // ram0 offset, held at zero while idle in ta mode
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_frame_offset0 <= '0;
        end else if (i_idle && i_system) begin
            o_frame_offset0 <= '0;
        end else begin
            o_frame_offset0 <= i_frame_offset;
        end
    end

endmodule

`default_nettype wire

/* logic/pass_counter.sv */
// pass counter and last-pass insertion
`timescale 1ns/1ps
`default_nettype none

module pass_counter #(
    parameter logic [bf_ctrl_pkg::CNT_W-1:0] CALC_NUM = 5'd2,   // passes per frame
    parameter logic [bf_ctrl_pkg::PAD_W-1:0] PAD_SIZE = 20'd0   // padding on last pass
) (
    input  logic                          i_arst,        // clock
    input  logic                          i_clk156m,     // async reset
    input  logic                          i_restart,     // back in wait-spec
    input  logic                          i_sp_end,      // one per finished calc
    input  logic                          i_pad_window,  // ch0 calc state
    output logic [bf_ctrl_pkg::CNT_W-1:0] o_pass_cnt,
    output logic                          o_all_done,    // every pass counted
    output logic [bf_ctrl_pkg::PAD_W-1:0] o_pad_size,
    output logic                          o_end_ins      // end code on this pass
);

    logic last_pass;

    // --------------------
    // passes since frame start
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_pass_cnt <= '0;
        end else if (i_restart) begin
            o_pass_cnt <= '0;
        end else if (i_sp_end) begin
            o_pass_cnt <= o_pass_cnt + 1'b1;
        end
    end

    assign o_all_done = (o_pass_cnt == CALC_NUM);
    assign last_pass  = (o_pass_cnt == CALC_NUM - 1'b1);

    // padding + end code only during ch0 calc of the last pass
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_pad_size <= '0;
            o_end_ins  <= 1'b0;
        end else if (i_pad_window && last_pass) begin
            o_pad_size <= PAD_SIZE;
            o_end_ins  <= 1'b1;
        end else begin
            o_pad_size <= '0;
            o_end_ins  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* logic/join_collector.sv */
// join-complete collector
`timescale 1ns/1ps
`default_nettype none

module join_collector (
    input  logic                           i_arst,      // clock
    input  logic                           i_clk156m,   // async reset
    input  logic                           i_clear,     // end-judge state
    input  logic [bf_ctrl_pkg::NUM_CH-1:0] i_join_end,  // per channel strobes
    output logic                           o_join_all,  // all channels joined
    output logic                           o_join_pulse
);

    import bf_ctrl_pkg::*;

    logic [NUM_CH-1:0] r_flag;     // sticky per channel
    logic [2:0]        r_all_dly;  // two delay stages plus edge tap of all-set

    // flags set on strobe and hold until the pass ends
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_flag <= '0;
        end else if (i_clear) begin
            r_flag <= '0;
        end else begin
            r_flag <= r_flag | i_join_end;
        end
    end

    assign o_join_all = &r_flag;

    // --------------------
    // rising edge of the twice delayed all-set
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_all_dly <= '0;
        end else begin
            r_all_dly <= {r_all_dly[1:0], o_join_all};
        end
    end

    assign o_join_pulse = r_all_dly[1] && !r_all_dly[2];

endmodule

`default_nettype wire

/* logic/bf_sequencer.sv */
// beam-forming sequence FSM
`timescale 1ns/1ps
`default_nettype none

module bf_sequencer (
    input  logic                           i_arst,            // clock
    input  logic                           i_clk156m,         // async reset
    input  logic                           i_frame_chg,       // restart request
    input  logic                           i_system,          // 1 ta, 0 fa
    input  logic [bf_ctrl_pkg::NUM_CH-1:0] i_sp_start,        // load strobes per channel
    input  logic                           i_param_end,       // vector transfer done
    input  logic [1:0]                     i_calc_start_ext,  // ch1, ch2 calc starts
    input  logic                           i_join_all,
    input  logic                           i_join_pulse,
    input  logic [bf_ctrl_pkg::NUM_CH-1:0] i_ddr_end,         // write-back done per channel
    input  logic                           i_all_done,        // last pass counted
    output logic                           o_idle,
    output logic                           o_restart,
    output logic                           o_pad_window,
    output logic                           o_join_clear,
    output logic                           o_param_start,
    output logic                           o_calc_start,
    output logic                           o_sp_end,
    output logic [bf_ctrl_pkg::NUM_CH-1:0] o_fa_en            // ddr output mux select
);

    import bf_ctrl_pkg::*;

    seq_state_t r_state;
    seq_state_t r_state_d;  // one cycle behind, for edge pulses
    seq_state_t nxt_state;

    // --------------------
    // next state
    always_comb begin
        nxt_state = r_state;
        case (r_state)
            ST_WAIT_SPEC:  if (!i_system || i_sp_start[0]) nxt_state = ST_WAIT_TRANS;
            ST_WAIT_TRANS: if (i_param_end) nxt_state = ST_LOAD_A_CH0;
            // ch0
            ST_LOAD_A_CH0: if (i_sp_start[0]) nxt_state = ST_LOAD_B_CH0;
            ST_LOAD_B_CH0: if (i_sp_start[0]) nxt_state = ST_CALC_CH0;
            ST_CALC_CH0:   if (o_calc_start) nxt_state = ST_LOAD_A_CH1;  // own pulse
            // ch1
            ST_LOAD_A_CH1: if (i_sp_start[1]) nxt_state = ST_LOAD_B_CH1;
            ST_LOAD_B_CH1: if (i_sp_start[1]) nxt_state = ST_CALC_CH1;
            ST_CALC_CH1:   if (i_calc_start_ext[0]) nxt_state = ST_LOAD_A_CH2;
            // ch2
            ST_LOAD_A_CH2: if (i_sp_start[2]) nxt_state = ST_LOAD_B_CH2;
            ST_LOAD_B_CH2: if (i_sp_start[2]) nxt_state = ST_CALC_CH2;
            ST_CALC_CH2:   if (i_calc_start_ext[1]) nxt_state = ST_LOAD_A_CH3;
            // ch3, waits for every channel to join
            ST_LOAD_A_CH3: if (i_sp_start[3]) nxt_state = ST_LOAD_B_CH3;
            ST_LOAD_B_CH3: if (i_sp_start[3]) nxt_state = ST_CALC_CH3;
            ST_CALC_CH3:   if (i_join_all) nxt_state = ST_WRITE_CH0;
            // ddr write-backs in order
            ST_WRITE_CH0:  if (i_ddr_end[0]) nxt_state = ST_WRITE_CH1;
            ST_WRITE_CH1:  if (i_ddr_end[1]) nxt_state = ST_WRITE_CH2;
            ST_WRITE_CH2:  if (i_ddr_end[2]) nxt_state = ST_WRITE_CH3;
            ST_WRITE_CH3:  if (i_ddr_end[3]) nxt_state = ST_END_JUDGE;
            ST_END_JUDGE: begin
                if (i_all_done) begin
                    nxt_state = ST_WAIT_SPEC;
                end else begin
                    nxt_state = ST_LOAD_A_CH0;  // next pass
                end
            end
            default:       nxt_state = ST_WAIT_SPEC;
        endcase
        if (i_frame_chg) begin
            nxt_state = ST_WAIT_SPEC;  // new frame wins from any state
        end
    end

    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_state   <= ST_WAIT_SPEC;
            r_state_d <= ST_WAIT_SPEC;
        end else begin
            r_state   <= nxt_state;
            r_state_d <= r_state;
        end
    end

    // --------------------
    // state levels
    assign o_idle       = (r_state == ST_WAIT_SPEC);
    assign o_restart    = o_idle && (r_state_d != ST_WAIT_SPEC);  // first idle cycle
    assign o_pad_window = (r_state == ST_CALC_CH0);
    assign o_join_clear = (r_state == ST_END_JUDGE);

    // --------------------
    // transition pulses, one edge after the move
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_param_start <= 1'b0;
            o_calc_start  <= 1'b0;
            o_sp_end      <= 1'b0;
        end else begin
            o_param_start <= (r_state_d == ST_WAIT_SPEC) && (r_state == ST_WAIT_TRANS);
            o_calc_start  <= (r_state_d == ST_LOAD_B_CH0) && (r_state == ST_CALC_CH0);
            o_sp_end      <= (i_system && (r_state_d == ST_WAIT_TRANS)
                              && (r_state == ST_LOAD_A_CH0))  // ta dummy end
                             || ((r_state_d == ST_LOAD_A_CH0) && (r_state == ST_LOAD_B_CH0))
                             || i_join_pulse;                 // all channels joined
        end
    end

    // channel owning the current state, end-judge belongs to ch0
    always_comb begin
        case (r_state)
            ST_LOAD_A_CH0, ST_LOAD_B_CH0, ST_CALC_CH0, ST_WRITE_CH0,
            ST_END_JUDGE:                                             o_fa_en = 4'b0001;
            ST_LOAD_A_CH1, ST_LOAD_B_CH1, ST_CALC_CH1, ST_WRITE_CH1: o_fa_en = 4'b0010;
            ST_LOAD_A_CH2, ST_LOAD_B_CH2, ST_CALC_CH2, ST_WRITE_CH2: o_fa_en = 4'b0100;
            ST_LOAD_A_CH3, ST_LOAD_B_CH3, ST_CALC_CH3, ST_WRITE_CH3: o_fa_en = 4'b1000;
            default:                                                  o_fa_en = 4'b0000;
        endcase
    end

endmodule

`default_nettype wire

/* logic/bf_ctrl_top.sv */
// beam-forming controller top
`timescale 1ns/1ps
`default_nettype none

module bf_ctrl_top #(
    parameter logic [bf_ctrl_pkg::FRAME_W-1:0] FRAME_MAX = 4'd7,
    parameter logic [bf_ctrl_pkg::CNT_W-1:0]   CALC_NUM  = 5'd2,   // 1, 2, 4, 8 or 16
    parameter logic [bf_ctrl_pkg::PAD_W-1:0]   PAD_SIZE  = 20'd0
) (
    input  logic                             i_arst,             // clock
    input  logic                             i_clk156m,          // async reset
    input  logic [bf_ctrl_pkg::FRAME_W-1:0]  i_frame_time,
    input  logic                             i_system,           // 1 ta, 0 fa
    input  logic                             i_sp_start,         // ch0 load strobe
    input  logic                             i_sp_start_fa05,
    input  logic                             i_sp_start_fa06,
    input  logic                             i_sp_start_fa07,
    input  logic                             i_sp_end,           // ch0 calc done
    input  logic                             i_param_end,
    input  logic [bf_ctrl_pkg::OFFSET_W-1:0] i_frame_offset,
    input  logic                             i_calc_start_fa05,
    input  logic                             i_calc_start_fa06,
    input  logic                             i_join_end_fa05,
    input  logic                             i_join_end_fa06,
    input  logic                             i_join_end_fa07,
    input  logic                             i_ddr_endp_fa04,
    input  logic                             i_ddr_endp_fa05,
    input  logic                             i_ddr_endp_fa06,
    input  logic                             i_ddr_endp_fa07,
    output logic [bf_ctrl_pkg::STAMP_W-1:0]  o_frame_time,
    output logic                             o_calc_start,
    output logic                             o_sp_end,
    output logic [bf_ctrl_pkg::PAD_W-1:0]    o_pad_size,
    output logic                             o_end_ins,
    output logic [bf_ctrl_pkg::OFFSET_W-1:0] o_frame_offset0,
    output logic                             o_param_start,
    output logic [bf_ctrl_pkg::NUM_CH-1:0]   o_fa_en
);

    import bf_ctrl_pkg::*;

    logic             frame_chg;
    logic             idle;
    logic             restart;
    logic             pad_window;
    logic             join_clear;
    logic [CNT_W-1:0] pass_cnt;
    logic             all_done;
    logic             join_all;
    logic             join_pulse;

    // --------------------
    // channel strobes, ch0 in bit 0
    frame_stamp #(
        .FRAME_MAX(FRAME_MAX),
        .CALC_NUM (CALC_NUM)
    ) u_frame_stamp (
        .i_arst         (i_arst),
        .i_clk156m      (i_clk156m),
        .i_frame_time   (i_frame_time),
        .i_idle         (idle),
        .i_system       (i_system),
        .i_calc_start   (o_calc_start),
        .i_pass_cnt     (pass_cnt),
        .i_frame_offset (i_frame_offset),
        .o_frame_chg    (frame_chg),
        .o_frame_time   (o_frame_time),
        .o_frame_offset0(o_frame_offset0)
    );

    pass_counter #(
        .CALC_NUM(CALC_NUM),
        .PAD_SIZE(PAD_SIZE)
    ) u_pass_counter (
        .i_arst      (i_arst),
        .i_clk156m   (i_clk156m),
        .i_restart   (restart),
        .i_sp_end    (i_sp_end),
        .i_pad_window(pad_window),
        .o_pass_cnt  (pass_cnt),
        .o_all_done  (all_done),
        .o_pad_size  (o_pad_size),
        .o_end_ins   (o_end_ins)
    );

    join_collector u_join_collector (
        .i_arst      (i_arst),
        .i_clk156m   (i_clk156m),
        .i_clear     (join_clear),
        .i_join_end  ({i_join_end_fa07, i_join_end_fa06, i_join_end_fa05, i_sp_end}),
        .o_join_all  (join_all),
        .o_join_pulse(join_pulse)
    );

    bf_sequencer u_bf_sequencer (
        .i_arst          (i_arst),
        .i_clk156m       (i_clk156m),
        .i_frame_chg     (frame_chg),
        .i_system        (i_system),
        .i_sp_start      ({i_sp_start_fa07, i_sp_start_fa06, i_sp_start_fa05, i_sp_start}),
        .i_param_end     (i_param_end),
        .i_calc_start_ext({i_calc_start_fa06, i_calc_start_fa05}),
        .i_join_all      (join_all),
        .i_join_pulse    (join_pulse),
        .i_ddr_end       ({i_ddr_endp_fa07, i_ddr_endp_fa06, i_ddr_endp_fa05, i_ddr_endp_fa04}),
        .i_all_done      (all_done),
        .o_idle          (idle),
        .o_restart       (restart),
        .o_pad_window    (pad_window),
        .o_join_clear    (join_clear),
        .o_param_start   (o_param_start),
        .o_calc_start    (o_calc_start),
        .o_sp_end        (o_sp_end),
        .o_fa_en         (o_fa_en)
    );

endmodule

`default_nettype wire

/* tb/bf_ctrl_tb.sv */
// beam-forming controller testbench
`timescale 1ns/1ps
`default_nettype none

module bf_ctrl_tb;

    localparam logic [4:0]  CALC_NUM   = 5'd2;
    localparam logic [19:0] PAD_SIZE   = 20'h00123;
    localparam logic [3:0]  FRAME_MAX  = 4'd7;
    localparam int          MAX_CYCLES = 3000;  // ~5 frames of ~350 cycles plus margin
    localparam int          SEL_PARAM_END = 0;
    localparam int          SEL_SP0  = 1;
    localparam int          SEL_SP1  = 2;
    localparam int          SEL_SP2  = 3;
    localparam int          SEL_SP3  = 4;
    localparam int          SEL_SP_END = 5;
    localparam int          SEL_CALC5 = 6;
    localparam int          SEL_CALC6 = 7;
    localparam int          SEL_JOIN5 = 8;
    localparam int          SEL_JOIN6 = 9;
    localparam int          SEL_JOIN7 = 10;
    localparam int          SEL_DDR4 = 11;
    localparam int          SEL_DDR5 = 12;
    localparam int          SEL_DDR6 = 13;
    localparam int          SEL_DDR7 = 14;

    logic        i_arst;      // clock
    logic        i_clk156m;   // reset
    logic [3:0]  i_frame_time;
    logic        i_system;
    logic        i_sp_start, i_sp_start_fa05, i_sp_start_fa06, i_sp_start_fa07;
    logic        i_sp_end;
    logic        i_param_end;
    logic [31:0] i_frame_offset = '0;
    logic        i_calc_start_fa05, i_calc_start_fa06;
    logic        i_join_end_fa05, i_join_end_fa06, i_join_end_fa07;
    logic        i_ddr_endp_fa04, i_ddr_endp_fa05, i_ddr_endp_fa06, i_ddr_endp_fa07;
    logic [4:0]  o_frame_time;
    logic        o_calc_start;
    logic        o_sp_end;
    logic [19:0] o_pad_size;
    logic        o_end_ins;
    logic [31:0] o_frame_offset0;
    logic        o_param_start;
    logic [3:0]  o_fa_en;

    // tb side models
    int          cycle_cnt = 0;
    logic        offset_run = 1'b0;  // randomize offset once out of first reset
    logic [4:0]  model_pass;         // i_sp_end strobes since frame start
    logic [4:0]  calc_cnt;           // calc starts this frame
    logic [1:0]  param_cnt;          // param starts since channels went idle
    logic        start0_seen;
    logic [3:0]  fa_prev = '0;
    logic [3:0]  frame_prev = FRAME_MAX;
    logic        calc_prev = 1'b0;
    logic [31:0] offset_prev = '0;
    logic        system_prev = 1'b0;
    logic [4:0]  stamp_exp = '0;
    int unsigned seed_val;

    bf_ctrl_top #(
        .FRAME_MAX(FRAME_MAX),
        .CALC_NUM (CALC_NUM),
        .PAD_SIZE (PAD_SIZE)
    ) i_dut (.*);

    // --------------------
    // 40 ns clock
    initial begin
        i_arst = 1'b0;
        forever #20 i_arst = ~i_arst;
    end

    task automatic report_fail(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "check failed");
    endtask

    always @(posedge i_arst) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: sequence stalled after %0d cycles", cycle_cnt);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // --------------------
    // reference models on sampled values
    always @(posedge i_arst) begin
        fa_prev     <= o_fa_en;
        frame_prev  <= i_frame_time;
        calc_prev   <= o_calc_start;
        offset_prev <= i_frame_offset;
        system_prev <= i_system;
        if (offset_run) i_frame_offset <= $urandom;
        if (o_calc_start) stamp_exp <= {frame_prev, model_pass[0]};  // frame + pass lsb
        if (i_clk156m) begin
            model_pass  <= '0;
            calc_cnt    <= '0;
            param_cnt   <= '0;
            start0_seen <= 1'b0;
        end else begin
            if (o_param_start) model_pass <= '0;
            else if (i_sp_end) model_pass <= model_pass + 1'b1;
            if (o_param_start) calc_cnt <= '0;
            else if (o_calc_start) calc_cnt <= calc_cnt + 1'b1;
            if (o_fa_en != 0) param_cnt <= '0;
            else if (o_param_start) param_cnt <= param_cnt + 1'b1;
            if (o_fa_en != 0 || o_param_start) start0_seen <= 1'b0;
            else if (i_sp_start) start0_seen <= 1'b1;
        end
    end

    // --------------------
    // checks
    a_onehot: assert property (@(posedge i_arst) $onehot0(o_fa_en))
        else report_fail("o_fa_en not one-hot");
    a_first_ch: assert property (@(posedge i_arst) disable iff (i_clk156m)
        (fa_prev == 0 && o_fa_en != 0) |-> (o_fa_en == 4'b0001 && param_cnt == 1))
        else report_fail("channel 0 not first or param start count wrong");
    a_order: assert property (@(posedge i_arst) disable iff (i_clk156m)
        (fa_prev != 0 && o_fa_en != 0 && o_fa_en != fa_prev)
        |-> o_fa_en == {fa_prev[2:0], fa_prev[3]})
        else report_fail("channel order broken");
    a_stamp: assert property (@(posedge i_arst) disable iff (i_clk156m)
        o_calc_start |=> o_frame_time == stamp_exp)
        else report_fail("frame stamp mismatch");
    a_pad: assert property (@(posedge i_arst) disable iff (i_clk156m)
        o_pad_size == (o_end_ins ? PAD_SIZE : 20'd0))
        else report_fail("pad size does not follow end code");
    a_end_ins: assert property (@(posedge i_arst) disable iff (i_clk156m)
        o_end_ins |-> (model_pass == CALC_NUM - 1'b1 && (o_calc_start || calc_prev)))
        else report_fail("end code outside last-pass ch0 calc");
    a_end_last: assert property (@(posedge i_arst) disable iff (i_clk156m)
        o_calc_start |-> o_end_ins == (model_pass == CALC_NUM - 1'b1))
        else report_fail("end code missing on last pass");
    a_ta_start: assert property (@(posedge i_arst) disable iff (i_clk156m)
        (i_system && o_param_start) |-> start0_seen)
        else report_fail("param start before start 0 in ta mode");
    a_offset: assert property (@(posedge i_arst) disable iff (i_clk156m)
        (fa_prev != 0 || !system_prev) |-> o_frame_offset0 == offset_prev)
        else report_fail("frame offset not registered");
    a_ta_dummy: assert property (@(posedge i_arst) disable iff (i_clk156m)
        (i_system && i_param_end) |-> ##2 o_sp_end)
        else report_fail("no dummy sp end after param end");
    a_frame_chg: assert property (@(posedge i_arst) disable iff (i_clk156m)
        (i_frame_time != frame_prev) |-> ##1 o_fa_en == 0)
        else report_fail("frame change did not restart");

    // --------------------
    // responder
    task automatic set_strobe(input int sel, input logic val);
        case (sel)
            SEL_PARAM_END: i_param_end <= val;
            SEL_SP0:    i_sp_start <= val;
            SEL_SP1:    i_sp_start_fa05 <= val;
            SEL_SP2:    i_sp_start_fa06 <= val;
            SEL_SP3:    i_sp_start_fa07 <= val;
            SEL_SP_END: i_sp_end <= val;
            SEL_CALC5:  i_calc_start_fa05 <= val;
            SEL_CALC6:  i_calc_start_fa06 <= val;
            SEL_JOIN5:  i_join_end_fa05 <= val;
            SEL_JOIN6:  i_join_end_fa06 <= val;
            SEL_JOIN7:  i_join_end_fa07 <= val;
            SEL_DDR4:   i_ddr_endp_fa04 <= val;
            SEL_DDR5:   i_ddr_endp_fa05 <= val;
            SEL_DDR6:   i_ddr_endp_fa06 <= val;
            default:    i_ddr_endp_fa07 <= val;
        endcase
    endtask

    task automatic send_strobe(input int sel);  // 1..6 cycle delay then one cycle high
        int unsigned dly;
        dly = 1 + ($urandom % 6);
        repeat (dly) @(posedge i_arst);
        set_strobe(sel, 1'b1);
        @(posedge i_arst);
        set_strobe(sel, 1'b0);
    endtask

    task automatic wait_calc_start();
        do @(posedge i_arst); while (!o_calc_start);
    endtask

    task automatic wait_param_start();
        do @(posedge i_arst); while (!o_param_start);
    endtask

    task automatic wait_fa_idle();
        do @(posedge i_arst); while (o_fa_en != 0);
    endtask

    task automatic run_pass();
        send_strobe(SEL_SP0);
        send_strobe(SEL_SP0);
        wait_calc_start();
        send_strobe(SEL_SP_END);
        send_strobe(SEL_SP1);
        send_strobe(SEL_SP1);
        send_strobe(SEL_CALC5);
        send_strobe(SEL_JOIN5);
        send_strobe(SEL_SP2);
        send_strobe(SEL_SP2);
        send_strobe(SEL_CALC6);
        send_strobe(SEL_JOIN6);
        send_strobe(SEL_SP3);
        send_strobe(SEL_SP3);
        send_strobe(SEL_JOIN7);  // completes join so ch3 calc exits
        send_strobe(SEL_DDR4);
        send_strobe(SEL_DDR5);
        send_strobe(SEL_DDR6);
        send_strobe(SEL_DDR7);
    endtask

    task automatic run_frame();
        int k;
        wait_param_start();
        send_strobe(SEL_PARAM_END);
        for (k = 0; k < CALC_NUM; k++) begin
            run_pass();
        end
        wait_fa_idle();
        assert (calc_cnt == CALC_NUM) else report_fail("calc start count per frame");
    endtask

    task automatic run_aborted_frame();
        wait_param_start();
        send_strobe(SEL_PARAM_END);
        send_strobe(SEL_SP0);
        send_strobe(SEL_SP0);
        wait_calc_start();
        send_strobe(SEL_SP_END);
        send_strobe(SEL_SP1);
        i_frame_time <= i_frame_time + 1'b1;  // new frame mid ch1
        wait_fa_idle();
    endtask

    // --------------------
    // main sequence
    initial begin
        seed_val = $urandom(32'hec97_875b);
        i_clk156m = 1'b1;
        i_frame_time = FRAME_MAX;
        i_system = 1'b0;  // fa first
        {i_sp_start, i_sp_start_fa05, i_sp_start_fa06, i_sp_start_fa07} = '0;
        {i_sp_end, i_param_end, i_calc_start_fa05, i_calc_start_fa06} = '0;
        {i_join_end_fa05, i_join_end_fa06, i_join_end_fa07} = '0;
        {i_ddr_endp_fa04, i_ddr_endp_fa05, i_ddr_endp_fa06, i_ddr_endp_fa07} = '0;
        repeat (16) @(posedge i_arst);
        i_clk156m <= 1'b0;
        offset_run <= 1'b1;
        @(negedge i_arst);
        assert (!o_param_start && !o_calc_start && !o_sp_end && o_pad_size == 0
                && !o_end_ins && o_fa_en == 0)
            else report_fail("outputs not quiet after reset");
        run_frame();
        run_frame();
        run_aborted_frame();
        run_frame();  // restarted frame with pass 0 in first stamp
        // ta mode from a fresh reset
        @(posedge i_arst);
        i_clk156m <= 1'b1;
        i_system  <= 1'b1;
        repeat (16) @(posedge i_arst);
        i_clk156m <= 1'b0;
        repeat (5) @(posedge i_arst);
        @(negedge i_arst);
        assert (o_frame_offset0 == 0 && o_fa_en == 0) else report_fail("ta idle offset");
        send_strobe(SEL_SP0);  // start 0
        run_frame();
        repeat (4) @(posedge i_arst);
        @(negedge i_arst);
        assert (o_frame_offset0 == 0 && o_fa_en == 0) else report_fail("ta end offset");
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
logic/bf_ctrl_pkg.sv
logic/frame_stamp.sv
logic/pass_counter.sv
logic/join_collector.sv
logic/bf_sequencer.sv
logic/bf_ctrl_top.sv
tb/bf_ctrl_tb.sv
